//--- list.f
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/riscv_core.sv
+incdir+tests
tests/riscv_core_tb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --assert --top-module riscv_core_tb -f list.f \
    && ./obj_dir/Vriscv_core_tb > sim.log 2>&1 \
    || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1
exit 0

//--- tests/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// --------------------
// random source and encoders
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
endfunction

// one random instruction at slot idx with jumps forward and no further than last
function automatic logic [31:0] gen_body(input int idx, input int last);
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [11:0] mem_off;
    int          kind;
    int          tgt;
    r       = next_rand();
    rd      = {2'b00, r[2:0]};
    rs1     = {2'b00, r[5:3]};
    rs2     = {2'b00, r[8:6]};
    f3      = (r[11:9] == 3'd3) ? 3'd2 : r[11:9];
    kind    = int'(r[31:16] % 16'd10);
    mem_off = {7'b0, r[15:13], 2'b00};
    tgt     = idx + 1 + int'(r[14:13]);
    if (tgt > last) begin
        tgt = last;
    end
    case (kind)
        0, 1, 2, 3: begin
            return enc_r((r[12] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                         rs2, rs1, f3, rd);
        end
        4, 5: begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {(r[12] && f3 == 3'd5) ? 7'h20 : 7'h00, r[28:24]};
            end else begin
                imm = r[27:16];
            end
            return enc_i(imm, rs1, f3, rd, 7'h13);
        end
        6:       return enc_s(mem_off, rs2, 5'd0);
        7:       return enc_i(mem_off, 5'd0, 3'b010, rd, 7'h03);
        8:       return enc_b(13'((tgt - idx) * 4), rs2, rs1, r[12] ? 3'b001 : 3'b000);
        default: return enc_j(21'((tgt - idx) * 4), rd);
    endcase
endfunction

// first data words cleared by stores, then the random body and the self-loop
function automatic void gen_program();
    for (int i = 0; i < 256; i++) begin
        prog[i] = 32'h0000006f;
    end
    for (int i = 0; i < 8; i++) begin
        prog[i] = enc_s(12'(i * 4), 5'd0, 5'd0);
    end
    for (int i = 8; i < loop_slot; i++) begin
        prog[i] = gen_body(i, loop_slot);
        // about half the stores are read back by the next slot
        if (prog[i-1][6:0] == 7'h23) begin
            if (next_rand() % 2 == 1) begin
                prog[i] = enc_i({prog[i-1][31:25], prog[i-1][11:7]}, 5'd0, 3'b010,
                                {2'b00, prog[i][9:7]}, 7'h03);
            end
        end
    end
    prog[loop_slot] = enc_j(21'd0, 5'd0);
endfunction

// --------------------
// instruction-level model
function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        3'd7:    return a & b;
        default: return alt ? a - b : a + b;
    endcase
endfunction

function automatic void run_model();
    logic [31:0] regs [32];
    logic [31:0] mem [256];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] val;
    logic [31:0] imm_i;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        wr;
    int          steps;
    exp_rd.delete();
    exp_data.delete();
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        mem[i] = '0;
    end
    pc    = '0;
    steps = 0;
    while (pc != 32'(loop_slot * 4) && steps < 200) begin
        ins   = prog[pc[9:2]];
        rd    = ins[11:7];
        f3    = ins[14:12];
        a     = regs[ins[19:15]];
        b     = regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        wr    = 1'b0;
        val   = '0;
        case (ins[6:0])
            7'h33: begin
                wr  = 1'b1;
                val = alu_calc(f3, ins[30], a, b);
            end
            7'h13: begin
                wr  = 1'b1;
                val = alu_calc(f3, ins[30] && (f3 == 3'd5), a, imm_i);
            end
            7'h03: begin
                addr = a + imm_i;
                wr   = 1'b1;
                val  = mem[addr[9:2]];
            end
            7'h23: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mem[addr[9:2]] = b;
            end
            default: ;
        endcase
        if (ins[6:0] == 7'h63 && ((a == b) != ins[12])) begin
            pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end else if (ins[6:0] == 7'h6f) begin
            wr  = 1'b1;
            val = pc + 32'd4;
            pc  = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end else begin
            pc = pc + 32'd4;
        end
        // x0 stays zero and never shows on the write-back port
        if (wr && rd != 5'd0) begin
            regs[rd] = val;
            exp_rd.push_back(rd);
            exp_data.push_back(val);
        end
        steps++;
    end
endfunction

`endif

//--- tests/riscv_core_tb.sv
`timescale 1ns/10ps

module riscv_core_tb;

    localparam int num_programs = 20;
    localparam int loop_slot    = 40;
    localparam int watchdog_ns  = num_programs * 50 * 4 * 40;

    logic        sys_clk;
    logic        sys_rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] prog [256];
    logic [31:0] rng_state;
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];

    `include "rv_model.svh"

    riscv_core dut0 (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    initial begin
        sys_clk = 1'b0;
    end

    always #20 sys_clk = ~sys_clk;

    // --------------------
    // instruction port
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        return (addr[31:10] == '0) ? prog[addr[9:2]] : 32'h0000006f;
    endfunction

    always @(posedge sys_clk) begin
        #1;
        imem_data = fetch_word(imem_addr);
    end

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    // --------------------
    // checks sampled on the falling edge
    always @(negedge sys_clk) begin
        if (!sys_rst_n) begin
            assert (!wb_valid && imem_addr == core_pkg::reset_pc)
                else stop_with_fail($sformatf("FAILED at %0t: reset state pc=%h wb_valid=%b",
                                              $time, imem_addr, wb_valid));
        end else if (wb_valid) begin
            assert (exp_rd.size() > 0)
                else stop_with_fail($sformatf("FAILED at %0t: extra write-back x%0d=%h",
                                              $time, wb_rd, wb_data));
            assert (wb_rd == exp_rd[0] && wb_data == exp_data[0])
                else stop_with_fail($sformatf("FAILED at %0t: expected x%0d=%h, got x%0d=%h",
                                              $time, exp_rd[0], exp_data[0], wb_rd, wb_data));
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
        end
    end

    initial begin
        #(watchdog_ns);
        stop_with_fail("the run timed out before all programs reached their final loop");
    end

    initial begin
        sys_rst_n  = 1'b0;
        imem_data  = 32'h0000006f;
        rng_state  = 32'he65b;
        for (int i = 0; i < 256; i++) begin
            prog[i] = 32'h0000006f;
        end
        for (int p = 0; p < num_programs; p++) begin
            @(posedge sys_clk);
            #1;
            sys_rst_n = 1'b0;
            gen_program();
            run_model();
            repeat (5) @(posedge sys_clk);
            #1;
            sys_rst_n = 1'b1;
            // wait for the final loop and let the pipeline drain
            while (imem_addr != 32'(loop_slot * 4)) begin
                @(negedge sys_clk);
            end
            repeat (8) @(negedge sys_clk);
            assert (exp_rd.size() == 0)
                else stop_with_fail($sformatf("FAILED at %0t: program %0d missing %0d write-backs",
                                              $time, p, exp_rd.size()));
        end
        $display("** PASS **");
        $finish;
    end

endmodule

//--- rtl/riscv_core.sv
`timescale 1ns/10ps

module riscv_core (
    input  logic                              sys_clk,
    input  logic                              sys_rst_n,
    output logic [core_pkg::xlen-1:0]         imem_addr,
    input  logic [31:0]                       imem_data,
    output logic                              wb_valid,
    output logic [core_pkg::reg_addr_w-1:0]   wb_rd,
    output logic [core_pkg::xlen-1:0]         wb_data
);

    core_pkg::if_id_t                  if_id;
    core_pkg::id_ex_t                  id_ex;
    core_pkg::ex_mem_t                 ex_mem;
    core_pkg::wb_t                     wb;
    logic [core_pkg::reg_addr_w-1:0]   rs1;
    logic [core_pkg::reg_addr_w-1:0]   rs2;
    logic [core_pkg::xlen-1:0]         rs1_data;
    logic [core_pkg::xlen-1:0]         rs2_data;
    logic                              uses_rs2;
    logic                              is_branch;
    logic                              stall;
    logic                              redirect;
    logic [core_pkg::xlen-1:0]         redirect_pc;

    // --------------------
    // front end
    fetch_stage u_fetch (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .if_id       (if_id)
    );

    decode_stage u_decode (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .if_id       (if_id),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .uses_rs2    (uses_rs2),
        .is_branch   (is_branch),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .id_ex       (id_ex)
    );

    reg_file u_reg_file (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .wb        (wb),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    hazard_unit u_hazard (
        .rs1           (rs1),
        .rs2           (rs2),
        .uses_rs2      (uses_rs2),
        .is_branch     (is_branch),
        .id_ex_rd      (id_ex.rd),
        .id_ex_reg_wr  (id_ex.ctrl.reg_wr),
        .id_ex_mem_rd  (id_ex.ctrl.mem_rd),
        .ex_mem_rd     (ex_mem.rd),
        .ex_mem_reg_wr (ex_mem.reg_wr),
        .stall         (stall)
    );

    // --------------------
    // back end
    execute_stage u_execute (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .wb        (wb)
    );

    memory_stage u_memory (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .ex_mem    (ex_mem),
        .wb        (wb)
    );

    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

//--- rtl/memory_stage.sv
`timescale 1ns/10ps

module memory_stage (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  core_pkg::ex_mem_t   ex_mem,
    output core_pkg::wb_t       wb
);

    logic [core_pkg::xlen-1:0]                   dmem [core_pkg::dmem_words];
    logic [$clog2(core_pkg::dmem_words)-1:0]     word_addr;
    logic [core_pkg::xlen-1:0]                   load_data;

    // word addressed, byte offset dropped
    assign word_addr = ex_mem.alu_result[$clog2(core_pkg::dmem_words)+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge sys_clk) begin
        if (ex_mem.mem_wr) begin
            dmem[word_addr] <= ex_mem.store_data;
        end
    end

    // MEM/WB register
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= ex_mem.reg_wr && (ex_mem.rd != '0);
            wb.rd    <= ex_mem.rd;
            wb.data  <= ex_mem.mem_rd ? load_data : ex_mem.alu_result;
        end
    end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  core_pkg::id_ex_t    id_ex,
    output core_pkg::ex_mem_t   ex_mem,
    input  core_pkg::wb_t       wb
);

    core_pkg::fwd_sel_e        sel_a;
    core_pkg::fwd_sel_e        sel_b;
    logic [core_pkg::xlen-1:0] fwd_a;
    logic [core_pkg::xlen-1:0] fwd_b;
    logic [core_pkg::xlen-1:0] op_b;
    logic [core_pkg::xlen-1:0] result;

    // newest producer wins
    function automatic core_pkg::fwd_sel_e fwd_select(
        input logic [core_pkg::reg_addr_w-1:0] rs,
        input core_pkg::ex_mem_t               em,
        input core_pkg::wb_t                   w
    );
        if (em.reg_wr && (em.rd != '0) && (em.rd == rs)) begin
            return core_pkg::fwd_ex_mem;
        end else if (w.valid && (w.rd != '0) && (w.rd == rs)) begin
            return core_pkg::fwd_mem_wb;
        end
        return core_pkg::fwd_none;
    endfunction

    function automatic logic [core_pkg::xlen-1:0] fwd_mux(
        input core_pkg::fwd_sel_e        sel,
        input logic [core_pkg::xlen-1:0] reg_val,
        input logic [core_pkg::xlen-1:0] em_val,
        input logic [core_pkg::xlen-1:0] wb_val
    );
        case (sel)
            core_pkg::fwd_ex_mem: return em_val;
            core_pkg::fwd_mem_wb: return wb_val;
            default:              return reg_val;
        endcase
    endfunction

    // --------------------
    // operand select
    assign sel_a = fwd_select(id_ex.rs1, ex_mem, wb);
    assign sel_b = fwd_select(id_ex.rs2, ex_mem, wb);
    assign fwd_a = fwd_mux(sel_a, id_ex.rs1_data, ex_mem.alu_result, wb.data);
    assign fwd_b = fwd_mux(sel_b, id_ex.rs2_data, ex_mem.alu_result, wb.data);
    assign op_b  = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b;

    // --------------------
    // ALU
    always_comb begin
        case (id_ex.ctrl.alu_op)
            core_pkg::alu_sub: result = fwd_a - op_b;
            core_pkg::alu_and: result = fwd_a & op_b;
            core_pkg::alu_or:  result = fwd_a | op_b;
            core_pkg::alu_xor: result = fwd_a ^ op_b;
            core_pkg::alu_slt: result = core_pkg::xlen'($signed(fwd_a) < $signed(op_b));
            core_pkg::alu_sll: result = fwd_a << op_b[4:0];
            core_pkg::alu_srl: result = fwd_a >> op_b[4:0];
            core_pkg::alu_sra: result = $unsigned($signed(fwd_a) >>> op_b[4:0]);
            default:           result = fwd_a + op_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.reg_wr     <= id_ex.ctrl.reg_wr;
            ex_mem.mem_rd     <= id_ex.ctrl.mem_rd;
            ex_mem.mem_wr     <= id_ex.ctrl.mem_wr;
            ex_mem.alu_result <= result;
            // store data goes through the same forwarding as operand b
            ex_mem.store_data <= fwd_b;
            ex_mem.rd         <= id_ex.rd;
        end
    end

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
    input  logic [core_pkg::reg_addr_w-1:0]   rs1,
    input  logic [core_pkg::reg_addr_w-1:0]   rs2,
    input  logic                              uses_rs2,
    input  logic                              is_branch,
    input  logic [core_pkg::reg_addr_w-1:0]   id_ex_rd,
    input  logic                              id_ex_reg_wr,
    input  logic                              id_ex_mem_rd,
    input  logic [core_pkg::reg_addr_w-1:0]   ex_mem_rd,
    input  logic                              ex_mem_reg_wr,
    output logic                              stall
);

    logic hit_ex;
    logic hit_mem;
    logic load_use;
    logic branch_wait;

    // decode source matches a nonzero destination further down
    assign hit_ex  = (id_ex_rd != '0) &&
                     ((id_ex_rd == rs1) || (uses_rs2 && (id_ex_rd == rs2)));
    assign hit_mem = (ex_mem_rd != '0) &&
                     ((ex_mem_rd == rs1) || (uses_rs2 && (ex_mem_rd == rs2)));

    assign load_use = id_ex_mem_rd && hit_ex;

    // branch compares in decode, so wait until the producer writes back
    assign branch_wait = is_branch && ((id_ex_reg_wr && hit_ex) || (ex_mem_reg_wr && hit_mem));

    assign stall = load_use || branch_wait;

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                              sys_clk,
    input  logic                              sys_rst_n,
    input  core_pkg::wb_t                     wb,
    input  logic [core_pkg::reg_addr_w-1:0]   rs1,
    input  logic [core_pkg::reg_addr_w-1:0]   rs2,
    output logic [core_pkg::xlen-1:0]         rs1_data,
    output logic [core_pkg::xlen-1:0]         rs2_data
);

    logic [core_pkg::xlen-1:0] regs [2**core_pkg::reg_addr_w];

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < 2**core_pkg::reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write passes straight through to the read side
    assign rs1_data = (wb.valid && (wb.rd != '0) && (wb.rd == rs1)) ? wb.data : regs[rs1];
    assign rs2_data = (wb.valid && (wb.rd != '0) && (wb.rd == rs2)) ? wb.data : regs[rs2];

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                              sys_clk,
    input  logic                              sys_rst_n,
    input  core_pkg::if_id_t                  if_id,
    output logic [core_pkg::reg_addr_w-1:0]   rs1,
    output logic [core_pkg::reg_addr_w-1:0]   rs2,
    input  logic [core_pkg::xlen-1:0]         rs1_data,
    input  logic [core_pkg::xlen-1:0]         rs2_data,
    output logic                              uses_rs2,
    output logic                              is_branch,
    input  logic                              stall,
    output logic                              redirect,
    output logic [core_pkg::xlen-1:0]         redirect_pc,
    output core_pkg::id_ex_t                  id_ex
);

    core_pkg::opcode_e         opcode;
    core_pkg::ctrl_t           ctrl;
    logic [31:0]               instr;
    logic [core_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_j;
    logic [core_pkg::xlen-1:0] imm;
    logic                      is_jal;
    logic                      taken;

    // funct3 plus the alternate bit picks the ALU operation
    function automatic core_pkg::alu_op_e alu_decode(input logic [2:0] funct3,
                                                     input logic alt);
        case (funct3)
            3'b000:  return alt ? core_pkg::alu_sub : core_pkg::alu_add;
            3'b001:  return core_pkg::alu_sll;
            3'b010:  return core_pkg::alu_slt;
            3'b100:  return core_pkg::alu_xor;
            3'b101:  return alt ? core_pkg::alu_sra : core_pkg::alu_srl;
            3'b110:  return core_pkg::alu_or;
            3'b111:  return core_pkg::alu_and;
            default: return core_pkg::alu_add;
        endcase
    endfunction

    assign instr  = if_id.instr;
    assign opcode = core_pkg::opcode_e'(instr[6:0]);
    assign is_jal = if_id.valid && (opcode == core_pkg::op_jal);

    // jal carries no rs1, keep it off the hazard and forwarding checks
    assign rs1 = (opcode == core_pkg::op_jal) ? '0 : instr[19:15];
    assign rs2 = instr[24:20];

    assign uses_rs2  = (opcode == core_pkg::op_reg) || (opcode == core_pkg::op_store) ||
                       (opcode == core_pkg::op_branch);
    assign is_branch = if_id.valid && (opcode == core_pkg::op_branch);

    // --------------------
    // immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = imm_i;
        case (opcode)
            core_pkg::op_reg: begin
                ctrl.reg_wr = 1'b1;
                ctrl.alu_op = alu_decode(instr[14:12], instr[30]);
            end
            core_pkg::op_imm: begin
                ctrl.reg_wr  = 1'b1;
                ctrl.use_imm = 1'b1;
                // only the shift-right form uses bit 30
                ctrl.alu_op  = alu_decode(instr[14:12],
                                          instr[30] && (instr[14:12] == 3'b101));
            end
            core_pkg::op_load: begin
                ctrl.reg_wr  = 1'b1;
                ctrl.mem_rd  = 1'b1;
                ctrl.use_imm = 1'b1;
            end
            core_pkg::op_store: begin
                ctrl.mem_wr  = 1'b1;
                ctrl.use_imm = 1'b1;
                imm          = imm_s;
            end
            core_pkg::op_jal: begin
                // link value computed as pc + 4 in execute
                ctrl.reg_wr  = 1'b1;
                ctrl.use_imm = 1'b1;
                imm          = core_pkg::xlen'(4);
            end
            default: ;
        endcase
    end

    // --------------------
    // branch resolve
    assign taken = is_jal ||
                   (is_branch && ((instr[12] == 1'b0) == (rs1_data == rs2_data)));
    assign redirect    = taken && !stall;
    assign redirect_pc = if_id.pc + (is_jal ? imm_j : imm_b);

    // ID/EX register, bubble on stall or empty slot
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex.ctrl     <= (stall || !if_id.valid) ? '0 : ctrl;
            id_ex.rs1_data <= is_jal ? if_id.pc : rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= imm;
            id_ex.rs1      <= rs1;
            id_ex.rs2      <= rs2;
            id_ex.rd       <= instr[11:7];
        end
    end

endmodule

//--- rtl/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
    input  logic                        sys_clk,
    input  logic                        sys_rst_n,
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [core_pkg::xlen-1:0]   redirect_pc,
    output logic [core_pkg::xlen-1:0]   imem_addr,
    input  logic [31:0]                 imem_data,
    output core_pkg::if_id_t            if_id
);

    logic [core_pkg::xlen-1:0] pc;

    assign imem_addr = pc;

    // redirect wins over stall
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pc <= core_pkg::reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + core_pkg::xlen'(4);
        end
    end

    // IF/ID register
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            if_id <= '0;
        end else if (redirect) begin
            // drop the wrong-path fetch
            if_id <= '0;
        end else if (!stall) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= imem_data;
        end
    end

endmodule

//--- rtl/core_pkg.sv
package core_pkg;

    // --------------------
    // widths and sizes
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int dmem_words = 256;

    localparam logic [xlen-1:0] reset_pc = '0;

    // --------------------
    // encodings
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_ex_mem,
        fwd_mem_wb
    } fwd_sel_e;

    // --------------------
    // pipeline registers
    typedef struct packed {
        logic    reg_wr;
        logic    mem_rd;
        logic    mem_wr;
        logic    use_imm;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [xlen-1:0]       rs1_data;
        logic [xlen-1:0]       rs2_data;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_wr;
        logic                  mem_rd;
        logic                  mem_wr;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
    } ex_mem_t;

    // MEM/WB register, doubles as the register file write port
    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } wb_t;

endpackage
